// ==== verilog/pim_pkg.sv ====
package pim_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MODE_W = 3;

    // Memory-mapped addresses seen by the core
    localparam logic [ADDR_W-1:0] PIM_MODE_ADDR   = 32'h4100_0000;
    localparam logic [ADDR_W-1:0] PIM_ZP_ADDR     = 32'h4200_0000;
    localparam logic [ADDR_W-1:0] PIM_STATUS_ADDR = 32'h4300_0000;

    // Upper address bits that select a write class
    localparam logic [15:0] CELL_PREFIX   = 16'h4000;
    localparam logic [11:0] BUF_PREFIX    = 12'h400;
    localparam logic [15:0] PAR_GO_PREFIX = 16'h400F;

    // Field widths
    localparam int ROW_W      = 7;
    localparam int COL_W      = 9;
    localparam int PW_W       = 17;
    localparam int PC_W       = 5;
    localparam int EXEC_CNT_W = 4;
    localparam int RX_CNT_W   = 4;

    typedef enum logic [MODE_W-1:0] {
        MODE_NONE     = 3'd0,
        MODE_ERASE    = 3'd1,
        MODE_PROGRAM  = 3'd2,
        MODE_READ     = 3'd3,
        MODE_ZP       = 3'd4,
        MODE_PARALLEL = 3'd5
    } pim_mode_e;

    // Fixed execution lengths
    localparam logic [EXEC_CNT_W-1:0] READ_CYCLES = 4'd9;
    localparam logic [EXEC_CNT_W-1:0] PAR_CYCLES  = 4'd12;
    localparam logic [1:0]            PROC_CYCLES = 2'd2;

    typedef struct packed {
        logic              mode_wr;
        logic              cell_wr;
        logic              buf_wr;
        logic              par_go;
        logic              zp_wr;
        logic              status_rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } bus_cmd_t;

    typedef struct packed {
        pim_mode_e        mode;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [PW_W-1:0]  pulse_width;
        logic [PC_W-1:0]  pulse_count;
    } pim_cfg_t;

    typedef struct packed {
        logic                  en;
        pim_mode_e             mode;
        logic [ROW_W-1:0]      row;
        logic [COL_W-1:0]      col;
        logic [EXEC_CNT_W-1:0] exec_cnt;
        logic                  in_buf_rd;
    } cell_drive_t;

    typedef struct packed {
        logic                wr;
        logic [DATA_W-1:0]   data;
        logic [RX_CNT_W-1:0] rx_cnt;
    } in_buf_wr_t;

    typedef struct packed {
        logic                     en;
        logic signed [DATA_W-1:0] data;
    } zp_wr_t;

    typedef struct packed {
        logic rd_en;
        logic done;
    } out_proc_t;

endpackage

// ==== verilog/pim_bus_port.sv ====
`timescale 1ns/1ns

module pim_bus_port (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Core write port
    input  logic [pim_pkg::ADDR_W-1:0]  address_i,
    input  logic [pim_pkg::DATA_W-1:0]  data_i,

    // Status from the sequencer
    input  logic                        idle_i,
    input  logic                        data_valid_i,

    output pim_pkg::bus_cmd_t           cmd_o,
    output logic [pim_pkg::DATA_W-1:0]  data_o
);

    logic [15:0] addr_hi16;
    logic [11:0] addr_hi12;

    assign addr_hi16 = address_i[31:16];
    assign addr_hi12 = address_i[31:20];

    // Pure address decode, no mode or state knowledge here
    always_comb begin
        cmd_o           = '0;
        cmd_o.addr      = address_i;
        cmd_o.data      = data_i;
        cmd_o.mode_wr   = (address_i == pim_pkg::PIM_MODE_ADDR);
        cmd_o.cell_wr   = (addr_hi16 == pim_pkg::CELL_PREFIX);
        cmd_o.buf_wr    = (addr_hi12 == pim_pkg::BUF_PREFIX);
        cmd_o.par_go    = (addr_hi16 == pim_pkg::PAR_GO_PREFIX);
        cmd_o.zp_wr     = (address_i == pim_pkg::PIM_ZP_ADDR);
        cmd_o.status_rd = (address_i == pim_pkg::PIM_STATUS_ADDR);
    end

    // Status word returned one cycle after the read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_o <= '0;
        end else if (cmd_o.status_rd) begin
            data_o <= {{(pim_pkg::DATA_W-2){1'b0}}, data_valid_i, idle_i};
        end else begin
            data_o <= '0;
        end
    end

    // Register writes and the status read never share a cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({cmd_o.mode_wr, cmd_o.zp_wr, cmd_o.status_rd}))
        else $error("pim_bus_port: overlapping register decode");

endmodule

// ==== verilog/pim_cfg_regs.sv ====
`timescale 1ns/1ns

module pim_cfg_regs (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pim_pkg::bus_cmd_t   cmd_i,
    output pim_pkg::pim_cfg_t   cfg_o
);

    pim_pkg::pim_cfg_t cfg_q;

    logic [pim_pkg::ROW_W-1:0] cell_row;
    logic [pim_pkg::COL_W-1:0] cell_col;

    // Cell address is packed as {row, col} in the low address bits
    assign cell_row = cmd_i.addr[pim_pkg::COL_W +: pim_pkg::ROW_W];
    assign cell_col = cmd_i.addr[pim_pkg::COL_W-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
        end else if (cmd_i.mode_wr) begin
            cfg_q.mode <= pim_pkg::pim_mode_e'(cmd_i.data[pim_pkg::MODE_W-1:0]);
        end else if (cmd_i.cell_wr) begin
            case (cfg_q.mode)
                pim_pkg::MODE_ERASE, pim_pkg::MODE_PROGRAM: begin
                    cfg_q.row         <= cell_row;
                    cfg_q.col         <= cell_col;
                    cfg_q.pulse_width <= cmd_i.data[pim_pkg::PC_W +: pim_pkg::PW_W];
                    cfg_q.pulse_count <= cmd_i.data[pim_pkg::PC_W-1:0];
                end
                pim_pkg::MODE_READ, pim_pkg::MODE_PARALLEL: begin
                    // No pulse train in these modes
                    cfg_q.row         <= cell_row;
                    cfg_q.col         <= cell_col;
                    cfg_q.pulse_width <= '0;
                    cfg_q.pulse_count <= '0;
                end
                default: begin
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

endmodule

// ==== verilog/pim_pulse_timer.sv ====
`timescale 1ns/1ns

module pim_pulse_timer (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                start_i,
    input  pim_pkg::bus_cmd_t   cmd_i,
    input  pim_pkg::pim_cfg_t   cfg_i,

    output logic                pulse_on_o,
    output logic                last_pulse_o
);

    logic [pim_pkg::PW_W-1:0] width_q;
    logic [pim_pkg::PC_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            width_q <= '0;
            count_q <= '0;
        end else if (start_i) begin
            // Same cycle as the cell write, so take the fields off the bus
            width_q <= cmd_i.data[pim_pkg::PC_W +: pim_pkg::PW_W];
            count_q <= cmd_i.data[pim_pkg::PC_W-1:0];
        end else if (count_q != '0) begin
            if (width_q != '0) begin
                width_q <= width_q - 1'b1;
            end else begin
                // Gap cycle between pulses
                count_q <= count_q - 1'b1;
                width_q <= (count_q == 1) ? '0 : cfg_i.pulse_width;
            end
        end
    end

    assign pulse_on_o   = (count_q != '0) && (width_q != '0);
    assign last_pulse_o = (count_q == 1) && (width_q == '0);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> cmd_i.data[pim_pkg::PC_W-1:0] != '0)
        else $error("pim_pulse_timer: started with zero pulse count");

endmodule

// ==== verilog/pim_sequencer.sv ====
`timescale 1ns/1ns

module pim_sequencer (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  pim_pkg::bus_cmd_t       cmd_i,
    input  pim_pkg::pim_cfg_t       cfg_i,

    // Pulse timer handshake
    input  logic                    pulse_on_i,
    input  logic                    last_pulse_i,
    output logic                    start_o,

    // Status
    output logic                    idle_o,
    output logic                    data_valid_o,

    output pim_pkg::cell_drive_t    drive_o,
    output pim_pkg::in_buf_wr_t     in_buf_o,
    output pim_pkg::zp_wr_t         zp_o,
    output pim_pkg::out_proc_t      proc_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_EXEC,
        ST_PROC
    } state_e;

    state_e state_q, state_d;

    logic [pim_pkg::EXEC_CNT_W-1:0] exec_cnt_q;
    logic [1:0]                     proc_cnt_q;
    logic                           data_valid_q;

    logic is_pulse_mode;
    logic is_array_mode;
    logic setup_done;
    logic zp_done;
    logic to_proc;

    assign is_pulse_mode = (cfg_i.mode == pim_pkg::MODE_ERASE) ||
                           (cfg_i.mode == pim_pkg::MODE_PROGRAM);
    assign is_array_mode = (cfg_i.mode == pim_pkg::MODE_READ) ||
                           (cfg_i.mode == pim_pkg::MODE_PARALLEL);

    // PARALLEL ends setup on its own go prefix, the rest on a cell write
    assign setup_done = (state_q == ST_SETUP) &&
                        (((is_pulse_mode || cfg_i.mode == pim_pkg::MODE_READ) && cmd_i.cell_wr) ||
                         (cfg_i.mode == pim_pkg::MODE_PARALLEL && cmd_i.par_go));
    assign zp_done    = (state_q == ST_SETUP) && (cfg_i.mode == pim_pkg::MODE_ZP) && cmd_i.zp_wr;
    assign to_proc    = (state_q == ST_EXEC) && is_array_mode && (exec_cnt_q == '0);
    assign start_o    = setup_done && is_pulse_mode;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_i.mode_wr) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP: begin
                if (zp_done) begin
                    state_d = ST_IDLE;
                end else if (setup_done) begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC: begin
                if (is_pulse_mode && last_pulse_i) begin
                    state_d = ST_IDLE;
                end else if (to_proc) begin
                    state_d = ST_PROC;
                end
            end
            ST_PROC: begin
                if (proc_cnt_q == 2'd1) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exec_cnt_q <= '0;
            proc_cnt_q <= '0;
        end else begin
            if (setup_done && is_array_mode) begin
                exec_cnt_q <= (cfg_i.mode == pim_pkg::MODE_PARALLEL) ?
                              pim_pkg::PAR_CYCLES : pim_pkg::READ_CYCLES;
            end else if (exec_cnt_q != '0) begin
                exec_cnt_q <= exec_cnt_q - 1'b1;
            end

            // Loaded on entry only
            if (to_proc) begin
                proc_cnt_q <= pim_pkg::PROC_CYCLES;
            end else if (proc_cnt_q != '0) begin
                proc_cnt_q <= proc_cnt_q - 1'b1;
            end
        end
    end

    // Result valid near the end of the array window, dropped by the next mode
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_valid_q <= 1'b0;
        end else if (cmd_i.mode_wr) begin
            data_valid_q <= 1'b0;
        end else if (state_q == ST_EXEC && is_array_mode && exec_cnt_q == 4'd2) begin
            data_valid_q <= 1'b1;
        end
    end

    assign idle_o       = (state_q == ST_IDLE);
    assign data_valid_o = data_valid_q;

    always_comb begin
        drive_o  = '0;
        in_buf_o = '0;
        zp_o     = '0;
        proc_o   = '0;
        case (state_q)
            ST_SETUP: begin
                if (cfg_i.mode == pim_pkg::MODE_PARALLEL && cmd_i.buf_wr) begin
                    in_buf_o.wr     = 1'b1;
                    in_buf_o.data   = cmd_i.data;
                    in_buf_o.rx_cnt = cmd_i.addr[15 -: pim_pkg::RX_CNT_W];
                end
                if (zp_done) begin
                    zp_o.en   = 1'b1;
                    zp_o.data = signed'(cmd_i.data);
                end
            end
            ST_EXEC: begin
                if (is_pulse_mode) begin
                    drive_o.en   = pulse_on_i;
                    drive_o.mode = cfg_i.mode;
                    drive_o.row  = cfg_i.row;
                    drive_o.col  = cfg_i.col;
                end else if (is_array_mode && exec_cnt_q != '0) begin
                    drive_o.en        = 1'b1;
                    drive_o.mode      = cfg_i.mode;
                    drive_o.row       = cfg_i.row;
                    drive_o.col       = cfg_i.col;
                    drive_o.exec_cnt  = exec_cnt_q;
                    drive_o.in_buf_rd = (cfg_i.mode == pim_pkg::MODE_PARALLEL);
                end
            end
            ST_PROC: begin
                proc_o.rd_en = 1'b1;
                proc_o.done  = (proc_cnt_q == 2'd1);
            end
            default: begin
                drive_o = '0;
            end
        endcase
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(state_q == ST_EXEC && cfg_i.mode == pim_pkg::MODE_ZP))
        else $error("pim_sequencer: EXEC entered in ZP mode");

endmodule

// ==== verilog/pim_periph_ctrl.sv ====
`timescale 1ns/1ns

module pim_periph_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Core side
    input  logic [pim_pkg::ADDR_W-1:0]  address_i,
    input  logic [pim_pkg::DATA_W-1:0]  data_i,
    output logic [pim_pkg::DATA_W-1:0]  data_o,

    // Macro side
    output pim_pkg::cell_drive_t        drive_o,
    output pim_pkg::in_buf_wr_t         in_buf_o,
    output pim_pkg::zp_wr_t             zp_o,
    output pim_pkg::out_proc_t          proc_o
);

    pim_pkg::bus_cmd_t cmd;
    pim_pkg::pim_cfg_t cfg;

    logic start;
    logic pulse_on;
    logic last_pulse;
    logic idle;
    logic data_valid;

    pim_bus_port u_bus_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .address_i    (address_i),
        .data_i       (data_i),
        .idle_i       (idle),
        .data_valid_i (data_valid),
        .cmd_o        (cmd),
        .data_o       (data_o)
    );

    pim_cfg_regs u_cfg_regs (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .cmd_i  (cmd),
        .cfg_o  (cfg)
    );

    pim_pulse_timer u_pulse_timer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .cmd_i        (cmd),
        .cfg_i        (cfg),
        .pulse_on_o   (pulse_on),
        .last_pulse_o (last_pulse)
    );

    pim_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd_i        (cmd),
        .cfg_i        (cfg),
        .pulse_on_i   (pulse_on),
        .last_pulse_i (last_pulse),
        .start_o      (start),
        .idle_o       (idle),
        .data_valid_o (data_valid),
        .drive_o      (drive_o),
        .in_buf_o     (in_buf_o),
        .zp_o         (zp_o),
        .proc_o       (proc_o)
    );

endmodule

// ==== test/tb_pim_model.svh ====
// Reference model of the controller, stepped once per rising edge

typedef enum int {
    M_IDLE,
    M_SETUP,
    M_EXEC,
    M_PROC
} model_state_e;

model_state_e      m_state;
pim_pkg::pim_cfg_t m_cfg;
int unsigned       m_k;
logic              m_dv;
logic [31:0]       m_status;

function automatic pim_pkg::bus_cmd_t classify_write(input logic [31:0] addr,
                                                      input logic [31:0] data);
    pim_pkg::bus_cmd_t c;
    c           = '0;
    c.addr      = addr;
    c.data      = data;
    c.mode_wr   = (addr == pim_pkg::PIM_MODE_ADDR);
    c.cell_wr   = (addr[31:16] == pim_pkg::CELL_PREFIX);
    c.buf_wr    = (addr[31:20] == pim_pkg::BUF_PREFIX);
    c.par_go    = (addr[31:16] == pim_pkg::PAR_GO_PREFIX);
    c.zp_wr     = (addr == pim_pkg::PIM_ZP_ADDR);
    c.status_rd = (addr == pim_pkg::PIM_STATUS_ADDR);
    return c;
endfunction

function automatic logic is_pulse(input pim_pkg::pim_mode_e mode);
    return (mode == pim_pkg::MODE_ERASE) || (mode == pim_pkg::MODE_PROGRAM);
endfunction

// Drive window of READ and PARALLEL
function automatic int unsigned array_len(input pim_pkg::pim_mode_e mode);
    if (mode == pim_pkg::MODE_PARALLEL) begin
        return 12;
    end
    return 9;
endfunction

// C pulses of W cycles, each with one gap cycle
function automatic int unsigned train_len();
    return int'(m_cfg.pulse_count) * (int'(m_cfg.pulse_width) + 1);
endfunction

task automatic clear_model();
    m_state  = M_IDLE;
    m_cfg    = '0;
    m_k      = 0;
    m_dv     = 1'b0;
    m_status = '0;
endtask

task automatic expect_outputs(input pim_pkg::bus_cmd_t c,
                              output pim_pkg::cell_drive_t d,
                              output pim_pkg::in_buf_wr_t b,
                              output pim_pkg::zp_wr_t z,
                              output pim_pkg::out_proc_t p);
    int unsigned len;
    d   = '0;
    b   = '0;
    z   = '0;
    p   = '0;
    len = array_len(m_cfg.mode);
    case (m_state)
        M_SETUP: begin
            if (m_cfg.mode == pim_pkg::MODE_PARALLEL && c.buf_wr) begin
                b.wr     = 1'b1;
                b.data   = c.data;
                b.rx_cnt = c.addr[15:12];
            end
            if (m_cfg.mode == pim_pkg::MODE_ZP && c.zp_wr) begin
                z.en   = 1'b1;
                z.data = c.data;
            end
        end
        M_EXEC: begin
            if (is_pulse(m_cfg.mode)) begin
                d.en   = (m_k % (int'(m_cfg.pulse_width) + 1)) < int'(m_cfg.pulse_width);
                d.mode = m_cfg.mode;
                d.row  = m_cfg.row;
                d.col  = m_cfg.col;
            end else if (m_k < len) begin
                d.en        = 1'b1;
                d.mode      = m_cfg.mode;
                d.row       = m_cfg.row;
                d.col       = m_cfg.col;
                d.exec_cnt  = 4'(len - m_k);
                d.in_buf_rd = (m_cfg.mode == pim_pkg::MODE_PARALLEL);
            end
        end
        M_PROC: begin
            p.rd_en = 1'b1;
            p.done  = (m_k == 1);
        end
        default: begin
        end
    endcase
endtask

task automatic advance_state(input pim_pkg::bus_cmd_t c);
    pim_pkg::pim_mode_e mode;
    mode = m_cfg.mode;
    // Status word holds the flags seen before this edge
    m_status = c.status_rd ? {30'b0, m_dv, m_state == M_IDLE} : 32'h0;
    if (c.mode_wr) begin
        m_dv = 1'b0;
    end else if (m_state == M_EXEC && !is_pulse(mode) && m_k + 2 == array_len(mode)) begin
        m_dv = 1'b1;
    end
    case (m_state)
        M_IDLE: begin
            if (c.mode_wr) begin
                m_state = M_SETUP;
            end
        end
        M_SETUP: begin
            m_k = 0;
            if (mode == pim_pkg::MODE_ZP && c.zp_wr) begin
                m_state = M_IDLE;
            end else if ((is_pulse(mode) || mode == pim_pkg::MODE_READ) && c.cell_wr) begin
                m_state = M_EXEC;
            end else if (mode == pim_pkg::MODE_PARALLEL && c.par_go) begin
                m_state = M_EXEC;
            end
        end
        M_EXEC: begin
            m_k = m_k + 1;
            if (is_pulse(mode) && m_k == train_len()) begin
                m_state = M_IDLE;
            end else if (!is_pulse(mode) && m_k == array_len(mode) + 1) begin
                m_state = M_PROC;
                m_k     = 0;
            end
        end
        M_PROC: begin
            m_k = m_k + 1;
            if (m_k == 2) begin
                m_state = M_IDLE;
            end
        end
        default: begin
        end
    endcase
    // Cell address packs row above col
    if (c.mode_wr) begin
        m_cfg.mode = pim_pkg::pim_mode_e'(c.data[2:0]);
    end else if (c.cell_wr && is_pulse(mode)) begin
        m_cfg.row         = c.addr[15:9];
        m_cfg.col         = c.addr[8:0];
        m_cfg.pulse_width = c.data[21:5];
        m_cfg.pulse_count = c.data[4:0];
    end else if (c.cell_wr && (mode == pim_pkg::MODE_READ || mode == pim_pkg::MODE_PARALLEL)) begin
        m_cfg.row         = c.addr[15:9];
        m_cfg.col         = c.addr[8:0];
        m_cfg.pulse_width = '0;
        m_cfg.pulse_count = '0;
    end
endtask

// ==== test/tb_pim_periph_ctrl.sv ====
`timescale 1ns/1ns

module tb_pim_periph_ctrl;

    localparam int NUM_OPS        = 40;
    localparam int OP_CYCLES      = 60;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * OP_CYCLES;

    logic                 clk_i;
    logic                 rst_ni;
    logic [31:0]          address;
    logic [31:0]          wdata;
    logic [31:0]          rdata;
    pim_pkg::cell_drive_t drive;
    pim_pkg::in_buf_wr_t  in_buf;
    pim_pkg::zp_wr_t      zp;
    pim_pkg::out_proc_t   proc;

    logic [31:0] rng_state;
    logic [31:0] status_seen;
    string       test_name;
    int          cycle_cnt   = 0;
    int          drive_errs  = 0;
    int          buf_errs    = 0;
    int          zp_errs     = 0;
    int          proc_errs   = 0;
    int          status_errs = 0;

    `include "tb_pim_model.svh"

    pim_periph_ctrl DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .address_i (address),
        .data_i    (wdata),
        .data_o    (rdata),
        .drive_o   (drive),
        .in_buf_o  (in_buf),
        .zp_o      (zp),
        .proc_o    (proc)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    task automatic check_drive(input string name, input pim_pkg::cell_drive_t exp,
                               input pim_pkg::cell_drive_t act);
        if (act !== exp) begin
            drive_errs++;
            $display("** Error %s: drive_o expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_buf(input string name, input pim_pkg::in_buf_wr_t exp,
                             input pim_pkg::in_buf_wr_t act);
        if (act !== exp) begin
            buf_errs++;
            $display("** Error %s: in_buf_o expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_zp(input string name, input pim_pkg::zp_wr_t exp,
                            input pim_pkg::zp_wr_t act);
        if (act !== exp) begin
            zp_errs++;
            $display("** Error %s: zp_o expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_proc(input string name, input pim_pkg::out_proc_t exp,
                              input pim_pkg::out_proc_t act);
        if (act !== exp) begin
            proc_errs++;
            $display("** Error %s: proc_o expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            status_errs++;
            $display("** Error %s: data_o expected %h, actual %h", name, exp, act);
        end
    endtask

    // One bus cycle: drive, check settled outputs, then step the model
    task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
        pim_pkg::bus_cmd_t    cmd;
        pim_pkg::cell_drive_t exp_drive;
        pim_pkg::in_buf_wr_t  exp_buf;
        pim_pkg::zp_wr_t      exp_zp;
        pim_pkg::out_proc_t   exp_proc;
        @(negedge clk_i);
        address = addr;
        wdata   = data;
        #5;
        cmd = classify_write(addr, data);
        expect_outputs(cmd, exp_drive, exp_buf, exp_zp, exp_proc);
        check_drive(test_name, exp_drive, drive);
        check_buf(test_name, exp_buf, in_buf);
        check_zp(test_name, exp_zp, zp);
        check_proc(test_name, exp_proc, proc);
        check_status(test_name, m_status, rdata);
        status_seen = rdata;
        advance_state(cmd);
    endtask

    // Poll status until the controller reports idle
    task automatic wait_for_idle();
        logic done;
        done = 1'b0;
        while (!done) begin
            apply_write(pim_pkg::PIM_STATUS_ADDR, 32'h0);
            done = status_seen[0];
        end
    endtask

    task automatic run_operation(input int idx);
        pim_pkg::pim_mode_e mode;
        logic [31:0]        r;
        logic [31:0]        cell_addr;
        logic [3:0]         hi;
        int                 n;
        n = rand_range(0, 3);
        for (int i = 0; i < n; i++) begin
            if (next_rand() & 32'h1) begin
                apply_write(pim_pkg::PIM_STATUS_ADDR, next_rand());
            end else begin
                apply_write(32'h0, 32'h0);
            end
        end
        mode      = pim_pkg::pim_mode_e'(3'(rand_range(1, 5)));
        test_name = $sformatf("op %0d %s", idx, mode.name());
        r         = next_rand();
        apply_write(pim_pkg::PIM_MODE_ADDR, {r[31:3], mode});
        if (next_rand() & 32'h1) begin
            apply_write(pim_pkg::PIM_STATUS_ADDR, 32'h0);
        end
        cell_addr = {16'h4000, 7'(next_rand()), 9'(next_rand())};
        r         = next_rand();
        case (mode)
            pim_pkg::MODE_ERASE, pim_pkg::MODE_PROGRAM: begin
                apply_write(cell_addr, {r[31:22], 17'(rand_range(1, 6)), 5'(rand_range(1, 4))});
            end
            pim_pkg::MODE_READ: begin
                apply_write(cell_addr, r);
            end
            pim_pkg::MODE_PARALLEL: begin
                // Cell write also lands in the input buffer
                apply_write(cell_addr, r);
                n = rand_range(0, 3);
                for (int i = 0; i < n; i++) begin
                    r  = next_rand();
                    hi = 4'(rand_range(1, 14));
                    apply_write({12'h400, hi, r[15:0]}, next_rand());
                end
                r = next_rand();
                apply_write({16'h400F, r[15:0]}, next_rand());
            end
            default: begin
                apply_write(pim_pkg::PIM_ZP_ADDR, r);
            end
        endcase
        wait_for_idle();
    endtask

    initial begin
        rst_ni    = 1'b0;
        address   = 32'h0;
        wdata     = 32'h0;
        rng_state = 32'h783c_bfc5;
        test_name = "reset";
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        #5;
        check_drive(test_name, '0, drive);
        check_buf(test_name, '0, in_buf);
        check_zp(test_name, '0, zp);
        check_proc(test_name, '0, proc);
        check_status(test_name, 32'h0, rdata);
        rst_ni = 1'b1;

        // Idle flag right after reset
        apply_write(pim_pkg::PIM_STATUS_ADDR, 32'h0);
        apply_write(32'h0, 32'h0);

        for (int op = 0; op < NUM_OPS; op++) begin
            run_operation(op);
        end
        test_name = "final";
        apply_write(32'h0, 32'h0);

        $display("Error counts: drive %0d, in_buf %0d, zp %0d, proc %0d, status %0d",
                 drive_errs, buf_errs, zp_errs, proc_errs, status_errs);
        if (drive_errs + buf_errs + zp_errs + proc_errs + status_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== pim_periph_ctrl.f ====
+incdir+test
verilog/pim_pkg.sv
verilog/pim_bus_port.sv
verilog/pim_cfg_regs.sv
verilog/pim_pulse_timer.sv
verilog/pim_sequencer.sv
verilog/pim_periph_ctrl.sv
test/tb_pim_periph_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PIM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f pim_periph_ctrl.f \
    --top-module tb_pim_periph_ctrl -Mdir "$OBJ" -o sim_pim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_pim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
